//--- rtl/mfp_pkg.sv
`default_nettype none

package mfp_pkg;

    // ##################################################
    // wishbone bus types
    // ##################################################

    typedef logic [15:0] wb_addr_t;  // bit 15 picks the slave, 0 is RAM and 1 is GPIO.
    typedef logic [31:0] wb_data_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // ##################################################
    // uart commands and address map
    // ##################################################

    localparam logic [7:0] CMD_WRITE = 8'h57;  // followed by 2 address and 4 data bytes.
    localparam logic [7:0] CMD_READ  = 8'h52;  // followed by 2 address bytes.

    localparam logic [14:0] GPIO_LED_WORD = 15'd0;
    localparam logic [14:0] GPIO_IN_WORD  = 15'd1;

    localparam wb_addr_t LOG_BASE = 16'h00C0;  // first word of the 64 slot event log.

endpackage

`default_nettype wire

//--- rtl/mfp_debouncer.sv
`timescale 1ns/100ps
`default_nettype none

module mfp_debouncer #(
    parameter int WIDTH           = 6,
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] sw_in,
    output logic [WIDTH-1:0] sw_out
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [WIDTH-1:0] sync_0, sync_1;
    logic [CNT_W-1:0] stable_cnt [WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= '1;
            sync_1 <= '1;
            sw_out <= '1;  // keys read high when not pressed.
            for (int i = 0; i < WIDTH; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            sync_0 <= sw_in;
            sync_1 <= sync_0;
            for (int i = 0; i < WIDTH; i++) begin
                if (sync_1[i] == sw_out[i]) begin
                    stable_cnt[i] <= '0;  // any return to the old level restarts the wait.
                end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    sw_out[i]     <= sync_1[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mfp_uart_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module mfp_uart_bridge #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx,
    output logic             tx,
    output mfp_pkg::wb_req_t wb_req,
    input  mfp_pkg::wb_rsp_t wb_rsp
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [2:0] {F_CMD, F_ADDR, F_DATA, F_BUS, F_REPLY} frame_state_t;
    typedef enum logic {T_IDLE, T_SHIFT} tx_state_t;

    logic [1:0]        rx_sync;
    logic              rx_busy, rx_valid;
    logic [CNT_W-1:0]  rx_cnt, tx_cnt;
    logic [3:0]        rx_bit, tx_bit;
    logic [7:0]        rx_byte;
    frame_state_t      f_state;
    logic [1:0]        byte_cnt;
    logic              we_q;
    mfp_pkg::wb_addr_t adr_q;
    mfp_pkg::wb_data_t dat_q, tx_word;
    tx_state_t         t_state;
    logic [9:0]        tx_frame;
    logic [2:0]        tx_left;
    logic              tx_load;

    // ##################################################
    // receiver
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_sync  <= 2'b11;
            rx_busy  <= 1'b0;
            rx_valid <= 1'b0;
            rx_cnt   <= '0;
            rx_bit   <= '0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                if (!rx_sync[1]) begin
                    rx_busy <= 1'b1;
                    rx_cnt  <= CNT_W'(CLKS_PER_BIT / 2);  // first sample lands mid start bit.
                    rx_bit  <= '0;
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                rx_bit <= rx_bit + 1'b1;
                if (rx_bit == 4'd0 && rx_sync[1]) begin
                    rx_busy <= 1'b0;  // start bit did not hold, so it was a glitch.
                end else if (rx_bit == 4'd9) begin
                    rx_busy  <= 1'b0;
                    rx_valid <= rx_sync[1];
                end else if (rx_bit != 4'd0) begin
                    rx_byte <= {rx_sync[1], rx_byte[7:1]};
                end
            end
        end
    end

    // ##################################################
    // frame parser and bus master
    // ##################################################

    assign tx_load = (f_state == F_BUS) && wb_rsp.ack && !we_q;
    assign wb_req  = '{cyc: f_state == F_BUS, stb: f_state == F_BUS,
                       we: we_q, adr: adr_q, dat: dat_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            f_state  <= F_CMD;
            byte_cnt <= '0;
            we_q     <= 1'b0;
        end else begin
            case (f_state)
                F_CMD: if (rx_valid) begin
                    byte_cnt <= '0;
                    we_q     <= (rx_byte == mfp_pkg::CMD_WRITE);
                    if (rx_byte == mfp_pkg::CMD_WRITE || rx_byte == mfp_pkg::CMD_READ) begin
                        f_state <= F_ADDR;
                    end
                end
                F_ADDR: if (rx_valid) begin
                    adr_q    <= {adr_q[7:0], rx_byte};  // high byte arrives first.
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd1) begin
                        byte_cnt <= '0;
                        f_state  <= we_q ? F_DATA : F_BUS;
                    end
                end
                F_DATA: if (rx_valid) begin
                    dat_q    <= {dat_q[23:0], rx_byte};
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) f_state <= F_BUS;
                end
                F_BUS: if (wb_rsp.ack) f_state <= we_q ? F_CMD : F_REPLY;
                F_REPLY: if (t_state == T_IDLE && tx_left == '0) f_state <= F_CMD;
                default: f_state <= F_CMD;
            endcase
        end
    end

    // ##################################################
    // reply transmitter
    // ##################################################

    assign tx = (t_state == T_SHIFT) ? tx_frame[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            t_state <= T_IDLE;
            tx_left <= '0;
            tx_cnt  <= '0;
            tx_bit  <= '0;
        end else begin
            if (tx_load) begin
                tx_word <= wb_rsp.dat;
                tx_left <= 3'd4;
            end
            case (t_state)
                T_IDLE: if (tx_left != '0) begin
                    tx_frame <= {1'b1, tx_word[31:24], 1'b0};  // stop, data, start.
                    tx_word  <= {tx_word[23:0], 8'h00};
                    tx_left  <= tx_left - 1'b1;
                    tx_cnt   <= CNT_W'(CLKS_PER_BIT - 1);
                    tx_bit   <= '0;
                    t_state  <= T_SHIFT;
                end
                T_SHIFT: if (tx_cnt != '0) begin
                    tx_cnt <= tx_cnt - 1'b1;
                end else begin
                    tx_cnt   <= CNT_W'(CLKS_PER_BIT - 1);
                    tx_frame <= {1'b1, tx_frame[9:1]};
                    tx_bit   <= tx_bit + 1'b1;
                    if (tx_bit == 4'd9) t_state <= T_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/mfp_event_logger.sv
`timescale 1ns/100ps
`default_nettype none

module mfp_event_logger (
    input  logic             clk,
    input  logic             rst,
    input  logic             key_db,
    input  logic [5:0]       inputs_db,
    output mfp_pkg::wb_req_t wb_req,
    input  mfp_pkg::wb_rsp_t wb_rsp
);

    logic        key_q;
    logic        pending;
    logic [15:0] count;
    logic [5:0]  inputs_q;  // inputs as seen at the press.

    always_ff @(posedge clk) begin
        if (rst) begin
            key_q      <= 1'b1;
            pending    <= 1'b0;
            count      <= '0;
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
        end else begin
            key_q <= key_db;

            if (!wb_req.cyc && pending) begin
                wb_req.cyc <= 1'b1;
                wb_req.stb <= 1'b1;
                wb_req.we  <= 1'b1;
                wb_req.adr <= mfp_pkg::LOG_BASE + {10'd0, count[5:0]};
                wb_req.dat <= {count, 10'd0, inputs_q};
                pending    <= 1'b0;
            end else if (wb_req.cyc && wb_rsp.ack) begin
                wb_req.cyc <= 1'b0;
                wb_req.stb <= 1'b0;
                count      <= count + 1'b1;
            end

            // a press during a bus cycle waits here until the bus is free.
            if (key_q && !key_db) begin
                pending  <= 1'b1;
                inputs_q <= inputs_db;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mfp_wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mfp_wb_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  mfp_pkg::wb_req_t m0_req,
    output mfp_pkg::wb_rsp_t m0_rsp,
    input  mfp_pkg::wb_req_t m1_req,
    output mfp_pkg::wb_rsp_t m1_rsp,
    output mfp_pkg::wb_req_t s0_req,
    input  mfp_pkg::wb_rsp_t s0_rsp,
    output mfp_pkg::wb_req_t s1_req,
    input  mfp_pkg::wb_rsp_t s1_rsp
);

    typedef enum logic [1:0] {G_IDLE, G_M0, G_M1} grant_t;

    grant_t            grant;
    logic              last_m1;  // set when m1 was served last.
    logic              live;
    mfp_pkg::wb_req_t  req_g;
    mfp_pkg::wb_rsp_t  rsp_sel;

    // ##################################################
    // grant
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            grant   <= G_IDLE;
            last_m1 <= 1'b0;
        end else begin
            case (grant)
                G_IDLE: if (m0_req.cyc && (!m1_req.cyc || last_m1)) begin
                    grant   <= G_M0;
                    last_m1 <= 1'b0;
                end else if (m1_req.cyc) begin
                    grant   <= G_M1;
                    last_m1 <= 1'b1;
                end
                G_M0: if (!m0_req.cyc) grant <= G_IDLE;
                G_M1: if (!m1_req.cyc) grant <= G_IDLE;
                default: grant <= G_IDLE;
            endcase
        end
    end

    // ##################################################
    // request decode and response return
    // ##################################################

    // stb is held back while the registered ack is on its way to the master.
    assign live    = (grant != G_IDLE) && !m0_rsp.ack && !m1_rsp.ack;
    assign req_g   = (grant == G_M1) ? m1_req : m0_req;
    assign rsp_sel = req_g.adr[15] ? s1_rsp : s0_rsp;

    always_comb begin
        s0_req     = req_g;
        s1_req     = req_g;
        s0_req.cyc = req_g.cyc && live && !req_g.adr[15];
        s0_req.stb = req_g.stb && live && !req_g.adr[15];
        s1_req.cyc = req_g.cyc && live && req_g.adr[15];
        s1_req.stb = req_g.stb && live && req_g.adr[15];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m0_rsp.ack <= 1'b0;
            m1_rsp.ack <= 1'b0;
        end else begin
            m0_rsp.ack <= (grant == G_M0) && rsp_sel.ack;
            m1_rsp.ack <= (grant == G_M1) && rsp_sel.ack;
            m0_rsp.dat <= rsp_sel.dat;
            m1_rsp.dat <= rsp_sel.dat;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mfp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mfp_ram #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  mfp_pkg::wb_req_t wb_req,
    output mfp_pkg::wb_rsp_t wb_rsp
);

    mfp_pkg::wb_data_t     mem [2**RAM_ADDR_W];
    logic [RAM_ADDR_W-1:0] idx;
    logic                  hit;

    assign idx = wb_req.adr[RAM_ADDR_W-1:0];  // upper bits wrap.
    assign hit = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    initial begin
        for (int i = 0; i < 2**RAM_ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit && wb_req.we) mem[idx] <= wb_req.dat;
        wb_rsp.dat <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (rst) wb_rsp.ack <= 1'b0;
        else     wb_rsp.ack <= hit;
    end

endmodule

`default_nettype wire

//--- rtl/mfp_gpio.sv
`timescale 1ns/100ps
`default_nettype none

module mfp_gpio (
    input  logic             clk,
    input  logic             rst,
    input  mfp_pkg::wb_req_t wb_req,
    output mfp_pkg::wb_rsp_t wb_rsp,
    input  logic [5:0]       inputs_db,
    output logic [7:0]       led
);

    logic        hit;
    logic [14:0] offset;

    assign hit    = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign offset = wb_req.adr[14:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rsp.ack <= 1'b0;
            led        <= '0;
        end else begin
            wb_rsp.ack <= hit;
            if (hit && wb_req.we && offset == mfp_pkg::GPIO_LED_WORD) led <= wb_req.dat[7:0];
        end
    end

    // the input word is read only.
    always_ff @(posedge clk) begin
        case (offset)
            mfp_pkg::GPIO_LED_WORD: wb_rsp.dat <= {24'd0, led};
            mfp_pkg::GPIO_IN_WORD:  wb_rsp.dat <= {26'd0, inputs_db};
            default:                wb_rsp.dat <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/de0_nano.sv
`timescale 1ns/100ps
`default_nettype none

module de0_nano #(
    parameter int CLKS_PER_BIT    = 434,
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int RAM_ADDR_W      = 8
) (
    input  logic       CLOCK_50,
    input  logic       rst,
    input  logic [1:0] KEY,
    input  logic [3:0] SW,
    output logic [7:0] LED,
    input  logic       UART_RX,
    output logic       UART_TX
);

    logic       clk;
    logic [5:0] inputs_db;  // keys in the upper two bits, switches below.

    mfp_pkg::wb_req_t bridge_req, logger_req, ram_req, gpio_req;
    mfp_pkg::wb_rsp_t bridge_rsp, logger_rsp, ram_rsp, gpio_rsp;

    assign clk = CLOCK_50;

    mfp_debouncer #(.WIDTH (6), .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)) mfp_debouncer (
        .clk    ( clk         ),
        .rst    ( rst         ),
        .sw_in  ( {KEY, SW}   ),
        .sw_out ( inputs_db   )
    );

    mfp_uart_bridge #(.CLKS_PER_BIT (CLKS_PER_BIT)) mfp_uart_bridge (
        .clk    ( clk         ),
        .rst    ( rst         ),
        .rx     ( UART_RX     ),
        .tx     ( UART_TX     ),
        .wb_req ( bridge_req  ),
        .wb_rsp ( bridge_rsp  )
    );

    mfp_event_logger mfp_event_logger (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .key_db    ( inputs_db [4] ),  // KEY[0].
        .inputs_db ( inputs_db     ),
        .wb_req    ( logger_req    ),
        .wb_rsp    ( logger_rsp    )
    );

    mfp_wb_arbiter mfp_wb_arbiter (
        .clk    ( clk        ),
        .rst    ( rst        ),
        .m0_req ( bridge_req ),
        .m0_rsp ( bridge_rsp ),
        .m1_req ( logger_req ),
        .m1_rsp ( logger_rsp ),
        .s0_req ( ram_req    ),
        .s0_rsp ( ram_rsp    ),
        .s1_req ( gpio_req   ),
        .s1_rsp ( gpio_rsp   )
    );

    mfp_ram #(.RAM_ADDR_W (RAM_ADDR_W)) mfp_ram (
        .clk    ( clk     ),
        .rst    ( rst     ),
        .wb_req ( ram_req ),
        .wb_rsp ( ram_rsp )
    );

    mfp_gpio mfp_gpio (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .wb_req    ( gpio_req  ),
        .wb_rsp    ( gpio_rsp  ),
        .inputs_db ( inputs_db ),
        .led       ( LED       )
    );

endmodule

`default_nettype wire

//--- test/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker #(
    parameter int CLKS_PER_BIT  = 8,
    parameter int REPLY_TIMEOUT = 2000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_tx,
    input  logic [7:0] led,
    input  logic [7:0] led_exp,
    output int         words_done,
    output int         mismatches,
    output int         protocol_errors
);

    logic [31:0] exp_words [$];
    string       exp_names [$];
    logic [31:0] word_buf;
    logic [7:0]  rx_byte;
    int          byte_count;
    int          wait_cycles;

    // called by the testbench top after it has sent a read frame.
    task automatic expect_reply(input logic [31:0] word, input string name);
        exp_words.push_back(word);
        exp_names.push_back(name);
    endtask

    task automatic receive_byte(output logic [7:0] b);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);  // middle of the start bit.
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx !== 1'b1) begin
            $display("UART reply byte %02h ended without a stop bit", b);
            protocol_errors++;
        end
    endtask

    task automatic compare_word(input logic [31:0] got);
        if (words_done >= exp_words.size()) begin
            $display("unexpected UART reply word %08h while no read was pending", got);
            protocol_errors++;
        end else begin
            if (got !== exp_words[words_done]) begin
                $display("[FAIL] %s: expected %08h, actual %08h",
                         exp_names[words_done], exp_words[words_done], got);
                mismatches++;
            end
            if (led !== led_exp) begin
                $display("[FAIL] %s LED: expected %02h, actual %02h",
                         exp_names[words_done], led_exp, led);
                mismatches++;
            end
            words_done++;
        end
    endtask

    // ##################################################
    // reply decoder
    // ##################################################

    always begin
        @(negedge clk);
        if (rst) begin
            byte_count  = 0;
            wait_cycles = 0;
        end else if (uart_tx === 1'b0) begin
            receive_byte(rx_byte);
            wait_cycles = 0;
            word_buf    = {word_buf[23:0], rx_byte};  // most significant byte comes first.
            byte_count++;
            if (byte_count == 4) begin
                byte_count = 0;
                compare_word(word_buf);
            end
        end else if (words_done < exp_words.size()) begin
            wait_cycles++;
            if (wait_cycles > REPLY_TIMEOUT) begin
                $display("no UART reply within %0d cycles in test %s",
                         REPLY_TIMEOUT, exp_names[words_done]);
                protocol_errors++;
                words_done++;
                byte_count  = 0;
                wait_cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_de0_nano.sv
`timescale 1ns/100ps
`default_nettype none

module tb_de0_nano;

    localparam int CLKS_PER_BIT    = 8;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int RAM_ADDR_W      = 8;
    localparam int SETTLE          = 4 * DEBOUNCE_CYCLES;  // covers sync flops and debounce time.
    // about 60 frames of up to 7 bytes at 80 cycles per byte, plus replies and margin.
    localparam int MAX_CYCLES      = 120000;

    logic        clk = 1'b0;
    logic        rst;
    logic [1:0]  key;
    logic [3:0]  sw;
    logic [7:0]  led;
    logic        uart_rx;
    logic        uart_tx;

    logic [31:0] ram_model [2**RAM_ADDR_W];
    logic [7:0]  led_model;
    logic [15:0] log_count;
    logic [15:0] adr;
    logic [31:0] dat;
    int          seed;
    int          posted;
    int          n;
    int          cycle_count = 0;
    int          words_done, mismatches, protocol_errors;

    de0_nano #(
        .CLKS_PER_BIT    ( CLKS_PER_BIT    ),
        .DEBOUNCE_CYCLES ( DEBOUNCE_CYCLES ),
        .RAM_ADDR_W      ( RAM_ADDR_W      )
    ) de0_nano_inst (
        .CLOCK_50 ( clk     ),
        .rst      ( rst     ),
        .KEY      ( key     ),
        .SW       ( sw      ),
        .LED      ( led     ),
        .UART_RX  ( uart_rx ),
        .UART_TX  ( uart_tx )
    );

    tb_checker #(.CLKS_PER_BIT (CLKS_PER_BIT)) checker_inst (
        .clk             ( clk             ),
        .rst             ( rst             ),
        .uart_tx         ( uart_tx         ),
        .led             ( led             ),
        .led_exp         ( led_model       ),
        .words_done      ( words_done      ),
        .mismatches      ( mismatches      ),
        .protocol_errors ( protocol_errors )
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // ##################################################
    // reference model
    // ##################################################

    function automatic logic [31:0] expected_word(input logic [15:0] a, input logic [5:0] inputs);
        if (!a[15]) return ram_model[a[RAM_ADDR_W-1:0]];  // the RAM wraps on its low bits.
        if (a[14:0] == mfp_pkg::GPIO_LED_WORD) return {24'd0, led_model};
        if (a[14:0] == mfp_pkg::GPIO_IN_WORD) return {26'd0, inputs};
        return 32'd0;
    endfunction

    // ##################################################
    // stimulus tasks
    // ##################################################

    task automatic send_byte(input logic [7:0] b);
        uart_rx = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        uart_rx = 1'b1;
        repeat (CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic uart_write(input logic [15:0] a, input logic [31:0] d);
        send_byte(mfp_pkg::CMD_WRITE);
        send_byte(a[15:8]);
        send_byte(a[7:0]);
        send_byte(d[31:24]);
        send_byte(d[23:16]);
        send_byte(d[15:8]);
        send_byte(d[7:0]);
        if (!a[15]) ram_model[a[RAM_ADDR_W-1:0]] = d;
        else if (a[14:0] == mfp_pkg::GPIO_LED_WORD) led_model = d[7:0];
    endtask

    task automatic uart_read_check(input logic [15:0] a, input string name);
        send_byte(mfp_pkg::CMD_READ);
        send_byte(a[15:8]);
        send_byte(a[7:0]);
        checker_inst.expect_reply(expected_word(a, {key, sw}), name);
        posted++;
        while (words_done < posted) @(negedge clk);
    endtask

    task automatic press_key0();
        logic [15:0] slot_adr;
        slot_adr = mfp_pkg::LOG_BASE + {10'd0, log_count[5:0]};
        key[0] = 1'b0;
        // KEY[0] itself already reads low in the logged inputs.
        ram_model[slot_adr[RAM_ADDR_W-1:0]] = {log_count, 10'd0, key[1], 1'b0, sw};
        log_count = log_count + 16'd1;
        repeat (SETTLE) @(negedge clk);
        key[0] = 1'b1;
        repeat (SETTLE) @(negedge clk);
    endtask

    // ##################################################
    // test sequence
    // ##################################################

    initial begin
        seed      = 32'h49e6;
        rst       = 1'b1;
        key       = 2'b11;
        sw        = 4'd0;
        uart_rx   = 1'b1;
        led_model = 8'd0;
        log_count = 16'd0;
        posted    = 0;
        for (int i = 0; i < 2**RAM_ADDR_W; i++) begin
            ram_model[i] = 32'd0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (SETTLE) @(negedge clk);

        for (n = 0; n < 20; n++) begin
            adr = 16'($random(seed)) & 16'h7fff;
            dat = $random(seed);
            uart_write(adr, dat);
            uart_read_check(adr, "ram write readback");
        end

        dat = $random(seed);
        uart_write({1'b1, mfp_pkg::GPIO_LED_WORD}, dat);
        uart_read_check({1'b1, mfp_pkg::GPIO_LED_WORD}, "led register");

        sw = 4'($random(seed));
        repeat (SETTLE) @(negedge clk);
        uart_read_check({1'b1, mfp_pkg::GPIO_IN_WORD}, "input readback");
        key[1] = 1'b0;
        repeat (SETTLE) @(negedge clk);
        uart_read_check({1'b1, mfp_pkg::GPIO_IN_WORD}, "input readback key1");
        key[1] = 1'b1;
        repeat (SETTLE) @(negedge clk);

        for (n = 0; n < 3; n++) begin
            sw = 4'($random(seed));
            repeat (SETTLE) @(negedge clk);
            press_key0();
        end
        for (n = 0; n < 3; n++) begin
            uart_read_check(mfp_pkg::LOG_BASE + 16'(n), "event log record");
        end

        // the press lands near the end of the frame, so both masters want the bus.
        for (n = 0; n < 3; n++) begin
            dat = $random(seed);
            fork
                uart_write(16'h0010 + 16'(n), dat);
                begin
                    repeat (546 + 3 * n) @(negedge clk);
                    press_key0();
                end
            join
            uart_read_check(16'h0010 + 16'(n), "contention bridge write");
            uart_read_check(mfp_pkg::LOG_BASE + 16'(3 + n), "contention log record");
        end

        dat = $random(seed);
        uart_write(16'h0020, dat);
        send_byte(8'hA5);  // none of these bytes is a command.
        send_byte(8'h00);
        send_byte(8'h20);
        send_byte(8'hDE);
        send_byte(8'hAD);
        send_byte(8'hBE);
        send_byte(8'hEF);
        repeat (400) @(negedge clk);
        uart_read_check(16'h0020, "unknown command ignored");

        repeat (200) @(negedge clk);
        $display("closing report: %0d/%0d words checked, %0d mismatches, %0d protocol errors",
                 words_done, posted, mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0 && words_done == posted) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/mfp_pkg.sv
rtl/mfp_debouncer.sv
rtl/mfp_uart_bridge.sv
rtl/mfp_event_logger.sv
rtl/mfp_wb_arbiter.sv
rtl/mfp_ram.sv
rtl/mfp_gpio.sv
rtl/de0_nano.sv
test/tb_checker.sv
test/tb_de0_nano.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_de0_nano -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -Fqx "All tests passed!"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
